// File: design/commit_pkg.sv
package commit_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  int_vec_t;

    // 0 byte, 1 half-word, 2 word
    typedef logic [1:0] mem_size_t;
    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    typedef enum logic [3:0] {
        NOP, ALU, LW, LH, LHU, LB, LBU, SW, SH, SB, SYSCALL, ERET
    } op_t;

    // MIPS cause numbers where one exists
    typedef enum logic [4:0] {
        EXC_INT  = 5'h00,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_SYS  = 5'h08,
        EXC_NONE = 5'h1f
    } exc_code_t;

    typedef struct packed {
        op_t       op;
        word_t     pc;
        // alu result, or the address for loads and stores
        word_t     result;
        word_t     store_data;
        word_t     epc;
        reg_addr_t destreg;
        logic      regwrite;
    } exec_data_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t destreg;
        logic      regwrite;
        word_t     result;
    } wb_data_t;

    typedef struct packed {
        logic      en;
        logic      wt;
        mem_size_t size;
        word_t     addr;
        word_t     wd;
    } mem_req_t;

    typedef struct packed {
        exc_code_t code;
        word_t     epc;
        word_t     badvaddr;
    } exception_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    function automatic logic is_load(op_t op);
        return (op == LW) || (op == LH) || (op == LHU) || (op == LB) || (op == LBU);
    endfunction

    function automatic logic is_store(op_t op);
        return (op == SW) || (op == SH) || (op == SB);
    endfunction

endpackage

// File: design/exception_check.sv
`timescale 1ns/1ps

module exception_check #(
    parameter commit_pkg::word_t EXC_VECTOR = 32'hBFC00380
) (
    input  commit_pkg::exec_data_t slot,
    input  logic                   squash,
    input  commit_pkg::int_vec_t   ext_int,
    input  logic                   check_int,
    output logic                   exc_valid,
    output commit_pkg::exception_t exc
);
    import commit_pkg::*;

    logic      misaligned;
    logic      int_pending;
    exc_code_t code;

    // word accesses need addr[1:0] == 0 and half-words need addr[0] == 0
    always_comb begin
        case (slot.op)
            LW, SW:      misaligned = (slot.result[1:0] != 2'b00);
            LH, LHU, SH: misaligned = slot.result[0];
            default:     misaligned = 1'b0;
        endcase
    end

    // no interrupt on the handler entry instruction itself,
    // so the handler always makes progress
    assign int_pending = check_int && (ext_int != '0) && (slot.pc != EXC_VECTOR);

    // interrupt first, then syscall, then address error
    always_comb begin
        code = EXC_NONE;
        if (int_pending) begin
            code = EXC_INT;
        end else if (slot.op == SYSCALL) begin
            code = EXC_SYS;
        end else if (misaligned && is_load(slot.op)) begin
            code = EXC_ADEL;
        end else if (misaligned && is_store(slot.op)) begin
            code = EXC_ADES;
        end
        // a squashed slot never reports
        if (squash) begin
            code = EXC_NONE;
        end
    end

    assign exc_valid    = (code != EXC_NONE);
    assign exc.code     = code;
    assign exc.epc      = slot.pc;
    assign exc.badvaddr = ((code == EXC_ADEL) || (code == EXC_ADES)) ? slot.result : '0;

endmodule

// File: design/store_format.sv
`timescale 1ns/1ps

module store_format (
    input  commit_pkg::op_t       op,
    input  commit_pkg::word_t     store_data,
    output commit_pkg::mem_size_t size,
    output commit_pkg::word_t     wd
);
    import commit_pkg::*;

    // the memory picks the lane from addr, so narrow data goes to every lane
    always_comb begin
        wd = store_data;
        case (op)
            SB: begin
                size = SIZE_BYTE;
                wd   = {4{store_data[7:0]}};
            end
            SH: begin
                size = SIZE_HALF;
                wd   = {2{store_data[15:0]}};
            end
            LB, LBU: begin
                size = SIZE_BYTE;
            end
            LH, LHU: begin
                size = SIZE_HALF;
            end
            default: begin
                size = SIZE_WORD;
            end
        endcase
    end

endmodule

// File: design/load_format.sv
`timescale 1ns/1ps

module load_format (
    input  commit_pkg::op_t   op,
    input  logic [1:0]        byte_sel,
    input  commit_pkg::word_t rdata,
    output commit_pkg::word_t load_data
);
    import commit_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // lane named by the low address bits
    always_comb begin
        case (byte_sel)
            2'd0:    lane_b = rdata[7:0];
            2'd1:    lane_b = rdata[15:8];
            2'd2:    lane_b = rdata[23:16];
            default: lane_b = rdata[31:24];
        endcase
    end

    assign lane_h = byte_sel[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (op)
            LB: begin
                load_data = {{24{lane_b[7]}}, lane_b};
            end
            LBU: begin
                load_data = {24'h000000, lane_b};
            end
            LH: begin
                load_data = {{16{lane_h[15]}}, lane_h};
            end
            LHU: begin
                load_data = {16'h0000, lane_h};
            end
            default: begin
                load_data = rdata;
            end
        endcase
    end

endmodule

// File: design/mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  commit_pkg::exec_data_t [1:0] slots,
    input  logic [1:0]                   allow,
    input  commit_pkg::word_t            dmem_rdata,
    output commit_pkg::mem_req_t         req,
    output commit_pkg::word_t            load_data,
    output logic                         mem_slot
);
    import commit_pkg::*;

    exec_data_t sel;
    logic       sel_mem;
    mem_size_t  size;
    word_t      wd;

    // older slot wins the single memory port
    assign mem_slot = is_load(slots[1].op) || is_store(slots[1].op);
    assign sel      = slots[mem_slot];
    assign sel_mem  = is_load(sel.op) || is_store(sel.op);

    store_format u_store_format (
        .op         (sel.op),
        .store_data (sel.store_data),
        .size       (size),
        .wd         (wd)
    );

    // excepting or squashed slots never reach memory
    assign req = '{
        en:   sel_mem && allow[mem_slot],
        wt:   is_store(sel.op),
        size: size,
        addr: sel.result,
        wd:   wd
    };

    load_format u_load_format (
        .op        (sel.op),
        .byte_sel  (sel.result[1:0]),
        .rdata     (dmem_rdata),
        .load_data (load_data)
    );

endmodule

// File: design/writeback_merge.sv
`timescale 1ns/1ps

module writeback_merge (
    input  commit_pkg::exec_data_t [1:0] slots,
    input  logic [1:0]                   keep,
    input  logic                         mem_slot,
    input  commit_pkg::word_t            load_data,
    output commit_pkg::wb_data_t   [1:0] out
);
    import commit_pkg::*;

    logic [1:0] takes_load;

    // only the slot that owns the memory port gets the loaded word
    assign takes_load[1] = mem_slot && is_load(slots[1].op);
    assign takes_load[0] = !mem_slot && is_load(slots[0].op);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            out[i].pc       = slots[i].pc;
            out[i].destreg  = slots[i].destreg;
            out[i].regwrite = slots[i].regwrite;
            out[i].result   = takes_load[i] ? load_data : slots[i].result;
            // dropped slots retire as an all-zero record
            if (!keep[i]) begin
                out[i] = '0;
            end
        end
    end

endmodule

// File: design/commit_stage.sv
`timescale 1ns/1ps

module commit_stage #(
    parameter commit_pkg::word_t EXC_VECTOR = 32'hBFC00380
) (
    input  commit_pkg::exec_data_t [1:0] in,
    input  logic                         first_cycle,
    input  commit_pkg::int_vec_t         ext_int,
    output commit_pkg::mem_req_t         dmem_req,
    input  commit_pkg::word_t            dmem_rdata,
    input  logic                         dmem_data_ok,
    output logic                         finish,
    output commit_pkg::wb_data_t   [1:0] out,
    output logic                         exception_valid,
    output commit_pkg::exception_t       exception,
    output commit_pkg::redirect_t        redirect
);
    import commit_pkg::*;

    logic       [1:0] exc_valid;
    exception_t [1:0] exc;
    logic             mask;
    logic       [1:0] live;
    word_t            load_data;
    logic             mem_slot;

    // slot 1 is older and alone sees interrupts
    exception_check #(.EXC_VECTOR(EXC_VECTOR)) u_check1 (
        .slot      (in[1]),
        .squash    (1'b0),
        .ext_int   (ext_int),
        .check_int (1'b1),
        .exc_valid (exc_valid[1]),
        .exc       (exc[1])
    );

    exception_check #(.EXC_VECTOR(EXC_VECTOR)) u_check0 (
        .slot      (in[0]),
        .squash    (mask),
        .ext_int   (ext_int),
        .check_int (1'b0),
        .exc_valid (exc_valid[0]),
        .exc       (exc[0])
    );

    // slot 1 trapping or returning kills the younger slot
    assign mask    = exc_valid[1] || (in[1].op == ERET);
    assign live[1] = !exc_valid[1];
    assign live[0] = !mask && !exc_valid[0];

    mem_access u_mem_access (
        .slots      (in),
        .allow      (live),
        .dmem_rdata (dmem_rdata),
        .req        (dmem_req),
        .load_data  (load_data),
        .mem_slot   (mem_slot)
    );

    writeback_merge u_writeback_merge (
        .slots     (in),
        .keep      (live),
        .mem_slot  (mem_slot),
        .load_data (load_data),
        .out       (out)
    );

    assign exception_valid = |exc_valid;
    assign exception       = exc_valid[1] ? exc[1] : exc[0];

    // data-ok is not trusted in the first cycle of a pair
    assign finish = first_cycle ? !dmem_req.en : (!dmem_req.en || dmem_data_ok);

    always_comb begin
        redirect = '0;
        if (exception_valid) begin
            redirect = '{valid: 1'b1, target: EXC_VECTOR};
        end else if (in[1].op == ERET) begin
            redirect = '{valid: 1'b1, target: in[1].epc};
        end else if (in[0].op == ERET) begin
            redirect = '{valid: 1'b1, target: in[0].epc};
        end
    end

endmodule

// File: design/commit_unit.sv
`timescale 1ns/1ps

module commit_unit #(
    parameter commit_pkg::word_t EXC_VECTOR = 32'hBFC00380
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  commit_pkg::exec_data_t [1:0] in,
    input  commit_pkg::int_vec_t         ext_int,
    output commit_pkg::mem_req_t         dmem_req,
    input  commit_pkg::word_t            dmem_rdata,
    input  logic                         dmem_data_ok,
    output logic                         out_valid,
    output commit_pkg::wb_data_t   [1:0] out,
    output logic                         exception_valid,
    output commit_pkg::exception_t       exception,
    output commit_pkg::redirect_t        redirect
);
    import commit_pkg::*;

    typedef enum logic {EMPTY, HOLD} state_t;

    state_t           state;
    exec_data_t [1:0] pair;
    logic             first_cycle;
    logic             finish;
    logic             accept;
    mem_req_t         stage_req;
    logic             stage_exc_valid;

    assign out_valid = (state == HOLD) && finish;
    // a retiring pair frees the latch on the same edge
    assign in_ready  = (state == EMPTY) || out_valid;
    assign accept    = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= EMPTY;
            first_cycle <= 1'b0;
        end else if (accept) begin
            state       <= HOLD;
            first_cycle <= 1'b1;
        end else begin
            first_cycle <= 1'b0;
            if (out_valid) begin
                state <= EMPTY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pair <= in;
        end
    end

    commit_stage #(.EXC_VECTOR(EXC_VECTOR)) u_commit_stage (
        .in              (pair),
        .first_cycle     (first_cycle),
        .ext_int         (ext_int),
        .dmem_req        (stage_req),
        .dmem_rdata      (dmem_rdata),
        .dmem_data_ok    (dmem_data_ok),
        .finish          (finish),
        .out             (out),
        .exception_valid (stage_exc_valid),
        .exception       (exception),
        .redirect        (redirect)
    );

    // an empty latch must not start an access or report a trap
    always_comb begin
        dmem_req    = stage_req;
        dmem_req.en = stage_req.en && (state == HOLD);
    end

    assign exception_valid = stage_exc_valid && (state == HOLD);

endmodule

// File: verification/commit_tb.sv
`timescale 1ns/1ps

module commit_tb;
    import commit_pkg::*;

    localparam word_t VEC     = 32'hBFC00380;
    localparam int    TIMEOUT = 40;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    exec_data_t [1:0] in;
    int_vec_t         ext_int;
    mem_req_t         dmem_req;
    word_t            dmem_rdata;
    logic             dmem_data_ok;
    logic             out_valid;
    wb_data_t   [1:0] out;
    logic             exception_valid;
    exception_t       exception;
    redirect_t        redirect;

    // memory model state
    word_t            mem [256];
    int               seed = 32'h943dd8ac;
    logic             busy;
    int               wait_cnt;
    mem_req_t         held_req;

    // captured at the retire edge
    wb_data_t   [1:0] got_out;
    logic             got_exc_valid;
    exception_t       got_exc;
    redirect_t        got_redir;
    mem_req_t         last_req;
    logic             req_seen;
    int               lat;
    int               errors = 0;
    int               timeouts = 0;

    commit_unit #(.EXC_VECTOR(VEC)) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in              (in),
        .ext_int         (ext_int),
        .dmem_req        (dmem_req),
        .dmem_rdata      (dmem_rdata),
        .dmem_data_ok    (dmem_data_ok),
        .out_valid       (out_valid),
        .out             (out),
        .exception_valid (exception_valid),
        .exception       (exception),
        .redirect        (redirect)
    );

    always #50 clk = ~clk;

    task automatic check_wb(string name, wb_data_t got, wb_data_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_exc(string name, exception_t got, exception_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_req(string name, mem_req_t got, mem_req_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic exec_data_t make_slot(op_t op, word_t pc, word_t res, word_t sd);
        exec_data_t s;
        s.op         = op;
        s.pc         = pc;
        s.result     = res;
        s.store_data = sd;
        s.epc        = pc + 32'h1000;
        s.destreg    = pc[6:2];
        s.regwrite   = op inside {ALU, LW, LH, LHU, LB, LBU};
        return s;
    endfunction

    function automatic wb_data_t expected_wb(exec_data_t s, word_t res);
        wb_data_t w;
        w.pc       = s.pc;
        w.destreg  = s.destreg;
        w.regwrite = s.regwrite;
        w.result   = res;
        return w;
    endfunction

    function automatic mem_size_t size_of(op_t op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd2;
        endcase
    endfunction

    function automatic word_t replicate_store(op_t op, word_t d);
        case (op)
            SB:      return {4{d[7:0]}};
            SH:      return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic word_t extend_load(op_t op, word_t w, logic [1:0] off);
        word_t sh;
        sh = w >> (8 * off);
        case (op)
            LB:      return {{24{sh[7]}}, sh[7:0]};
            LBU:     return {24'd0, sh[7:0]};
            LH:      return {{16{sh[15]}}, sh[15:0]};
            LHU:     return {16'd0, sh[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic word_t merge_lanes(word_t old, word_t wd, mem_size_t size,
                                          logic [1:0] off);
        word_t mask;
        case (size)
            2'd0:    mask = 32'h0000_00ff << (8 * off);
            2'd1:    mask = 32'h0000_ffff << (8 * off);
            default: mask = 32'hffff_ffff;
        endcase
        return (old & ~mask) | (wd & mask);
    endfunction

    // answers 1 to 4 cycles after the request and writes land with data-ok
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_data_ok <= 1'b0;
            dmem_rdata   <= '0;
            busy         <= 1'b0;
            wait_cnt     <= 0;
        end else if (dmem_data_ok) begin
            dmem_data_ok <= 1'b0;
        end else if (busy) begin
            check_req("dmem_req (held)", dmem_req, held_req);
            if (wait_cnt == 1) begin
                busy         <= 1'b0;
                dmem_data_ok <= 1'b1;
                dmem_rdata   <= mem[held_req.addr[9:2]];
                if (held_req.wt) begin
                    mem[held_req.addr[9:2]] <= merge_lanes(mem[held_req.addr[9:2]],
                        held_req.wd, held_req.size, held_req.addr[1:0]);
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (dmem_req.en) begin
            busy     <= 1'b1;
            held_req <= dmem_req;
            wait_cnt <= 1 + ($random(seed) & 3);
        end
    end

    task automatic send_pair(input exec_data_t [1:0] p, input int_vec_t irq);
        int n;
        @(negedge clk);
        in       = p;
        ext_int  = irq;
        in_valid = 1'b1;
        n = 0;
        @(posedge clk);
        while (!in_ready && n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (!in_ready) begin
            $display("timeout: the pair was never accepted");
            timeouts++;
        end
        @(negedge clk);
        in_valid = 1'b0;
        req_seen = 1'b0;
        n = 1;
        @(posedge clk);
        while (!out_valid && n < TIMEOUT) begin
            if (dmem_req.en) begin
                req_seen = 1'b1;
                last_req = dmem_req;
            end
            check_word("in_ready", {31'd0, in_ready}, 32'd0);
            n++;
            @(posedge clk);
        end
        if (!out_valid) begin
            $display("timeout: the pair never retired");
            timeouts++;
        end
        if (dmem_req.en) begin
            req_seen = 1'b1;
            last_req = dmem_req;
        end
        lat           = n;
        got_out       = out;
        got_exc_valid = exception_valid;
        got_exc       = exception;
        got_redir     = redirect;
        @(negedge clk);
        ext_int = '0;
    endtask

    task automatic expect_retire(wb_data_t e1, wb_data_t e0, logic ev, exception_t ee,
                                 logic rv, word_t rt);
        check_wb("out[1]", got_out[1], e1);
        check_wb("out[0]", got_out[0], e0);
        check_word("exception_valid", {31'd0, got_exc_valid}, {31'd0, ev});
        if (ev) begin
            check_exc("exception", got_exc, ee);
        end
        check_word("redirect.valid", {31'd0, got_redir.valid}, {31'd0, rv});
        if (rv) begin
            check_word("redirect.target", got_redir.target, rt);
        end
    endtask

    task automatic expect_no_access();
        check_word("latency", word_t'(lat), 32'd1);
        check_word("dmem_req.en", {31'd0, req_seen}, 32'd0);
    endtask

    task automatic expect_access(mem_req_t exp);
        mem_req_t got;
        got = last_req;
        // write data means nothing on a read
        if (!exp.wt) begin
            got.wd = '0;
            exp.wd = '0;
        end
        check_word("dmem_req.en", {31'd0, req_seen}, 32'd1);
        check_req("dmem_req", got, exp);
    endtask

    task automatic alu_pairs();
        exec_data_t [1:0] p;
        check_word("out_valid", {31'd0, out_valid}, 32'd0);
        check_word("dmem_req.en", {31'd0, dmem_req.en}, 32'd0);
        check_word("exception_valid", {31'd0, exception_valid}, 32'd0);
        check_word("in_ready", {31'd0, in_ready}, 32'd1);
        for (int i = 0; i < 3; i++) begin
            p[1] = make_slot(ALU, 32'h400 + 32'(i) * 8, 32'h1111_0000 + 32'(i), 32'h0);
            p[0] = make_slot(ALU, 32'h404 + 32'(i) * 8, 32'h2222_0000 - 32'(i), 32'h0);
            send_pair(p, '0);
            expect_no_access();
            expect_retire(expected_wb(p[1], p[1].result), expected_wb(p[0], p[0].result),
                          1'b0, '0, 1'b0, '0);
        end
    endtask

    task automatic load_widths();
        op_t              ops [5];
        exec_data_t [1:0] p;
        exec_data_t       ld;
        exec_data_t       alu;
        wb_data_t         exp_ld;
        mem_req_t         r;
        word_t            a;
        int               k;
        ops = '{LW, LH, LHU, LB, LBU};
        k = 0;
        foreach (ops[i]) begin
            for (int off = 0; off < 4; off++) begin
                if ((ops[i] == LW && off != 0) || (size_of(ops[i]) == 2'd1 && off % 2 != 0)) begin
                    continue;
                end
                a   = 32'h100 + 32'(k) * 4 + 32'(off);
                ld  = make_slot(ops[i], 32'h1000 + 32'(k) * 8, a, 32'h0);
                alu = make_slot(ALU, 32'h1004 + 32'(k) * 8, 32'h5a5a_0000 + 32'(k), 32'h0);
                // the load takes either slot
                if (k % 2 == 0) begin
                    p[1] = ld;
                    p[0] = alu;
                end else begin
                    p[1] = alu;
                    p[0] = ld;
                end
                send_pair(p, '0);
                r = '{en: 1'b1, wt: 1'b0, size: size_of(ops[i]), addr: a, wd: '0};
                expect_access(r);
                exp_ld = expected_wb(ld, extend_load(ops[i], mem[a[9:2]], a[1:0]));
                if (k % 2 == 0) begin
                    expect_retire(exp_ld, expected_wb(alu, alu.result), 1'b0, '0, 1'b0, '0);
                end else begin
                    expect_retire(expected_wb(alu, alu.result), exp_ld, 1'b0, '0, 1'b0, '0);
                end
                k++;
            end
        end
    endtask

    task automatic store_widths();
        op_t              ops [3];
        logic [1:0]       offs [3];
        exec_data_t [1:0] p;
        mem_req_t         r;
        word_t            a;
        word_t            d;
        word_t            merged;
        ops  = '{SB, SH, SW};
        offs = '{2'd1, 2'd2, 2'd0};
        foreach (ops[i]) begin
            a      = 32'h200 + 32'(i) * 4 + 32'(offs[i]);
            d      = 32'hc3a5_9e80 + 32'(i) * 32'h0101_0101;
            p[1]   = make_slot(ops[i], 32'h2000 + 32'(i) * 16, a, d);
            p[0]   = make_slot(ALU, 32'h2004 + 32'(i) * 16, 32'h0bad_0000 + 32'(i), 32'h0);
            merged = merge_lanes(mem[a[9:2]], replicate_store(ops[i], d), size_of(ops[i]),
                                 a[1:0]);
            send_pair(p, '0);
            r = '{en: 1'b1, wt: 1'b1, size: size_of(ops[i]), addr: a,
                  wd: replicate_store(ops[i], d)};
            expect_access(r);
            expect_retire(expected_wb(p[1], a), expected_wb(p[0], p[0].result),
                          1'b0, '0, 1'b0, '0);
            // read back the whole word
            p[1] = make_slot(LW, 32'h2008 + 32'(i) * 16, {a[31:2], 2'b00}, 32'h0);
            send_pair(p, '0);
            check_word("out[1].result", got_out[1].result, merged);
        end
    endtask

    task automatic slot1_traps();
        exec_data_t [1:0] p;
        exception_t       e;
        p[1] = make_slot(SYSCALL, 32'h3000, 32'h0, 32'h0);
        p[0] = make_slot(LW, 32'h3004, 32'h240, 32'h0);
        e    = '{code: EXC_SYS, epc: 32'h3000, badvaddr: 32'h0};
        send_pair(p, '0);
        expect_no_access();
        expect_retire('0, '0, 1'b1, e, 1'b1, VEC);
        p[1] = make_slot(LW, 32'h3010, 32'h202, 32'h0);
        p[0] = make_slot(ALU, 32'h3014, 32'h77, 32'h0);
        e    = '{code: EXC_ADEL, epc: 32'h3010, badvaddr: 32'h202};
        send_pair(p, '0);
        expect_no_access();
        expect_retire('0, '0, 1'b1, e, 1'b1, VEC);
        p[1] = make_slot(SH, 32'h3020, 32'h301, 32'hffff);
        p[0] = make_slot(SW, 32'h3024, 32'h300, 32'h1234);
        e    = '{code: EXC_ADES, epc: 32'h3020, badvaddr: 32'h301};
        send_pair(p, '0);
        expect_no_access();
        expect_retire('0, '0, 1'b1, e, 1'b1, VEC);
    endtask

    task automatic slot0_traps();
        exec_data_t [1:0] p;
        exception_t       e;
        p[1] = make_slot(ALU, 32'h4000, 32'h99, 32'h0);
        p[0] = make_slot(SW, 32'h4004, 32'h2f6, 32'h55);
        e    = '{code: EXC_ADES, epc: 32'h4004, badvaddr: 32'h2f6};
        send_pair(p, '0);
        expect_no_access();
        expect_retire(expected_wb(p[1], p[1].result), '0, 1'b1, e, 1'b1, VEC);
        // interrupt beats the syscall
        p[1] = make_slot(SYSCALL, 32'h4010, 32'h0, 32'h0);
        p[0] = make_slot(ALU, 32'h4014, 32'h98, 32'h0);
        e    = '{code: EXC_INT, epc: 32'h4010, badvaddr: 32'h0};
        send_pair(p, 6'h04);
        expect_no_access();
        expect_retire('0, '0, 1'b1, e, 1'b1, VEC);
    endtask

    task automatic eret_returns();
        exec_data_t [1:0] p;
        p[1] = make_slot(ERET, 32'h5000, 32'h0, 32'h0);
        p[0] = make_slot(LW, 32'h5004, 32'h280, 32'h0);
        send_pair(p, '0);
        expect_no_access();
        expect_retire(expected_wb(p[1], p[1].result), '0, 1'b0, '0, 1'b1, p[1].epc);
        p[1] = make_slot(ALU, 32'h5010, 32'h4242, 32'h0);
        p[0] = make_slot(ERET, 32'h5014, 32'h0, 32'h0);
        send_pair(p, '0);
        expect_no_access();
        expect_retire(expected_wb(p[1], p[1].result), expected_wb(p[0], p[0].result),
                      1'b0, '0, 1'b1, p[0].epc);
    endtask

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in           = '0;
        ext_int      = '0;
        dmem_rdata   = '0;
        dmem_data_ok = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = $random(seed);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        alu_pairs();
        load_widths();
        store_widths();
        slot1_traps();
        slot0_traps();
        eret_returns();
        $display("summary: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
design/commit_pkg.sv
design/exception_check.sv
design/store_format.sv
design/load_format.sv
design/mem_access.sv
design/writeback_merge.sv
design/commit_stage.sv
design/commit_unit.sv
verification/commit_tb.sv
